//--- hw/adc_frontend.sv
`default_nettype none

`include "afe_defs.svh"

module adc_frontend (
  input  wire logic               adc_clk,
  input  wire logic               arst_n_i,
  input  wire afe_pkg::dac_code_t adc_raw_a_i,  // neg slope raw code
  input  wire afe_pkg::dac_code_t adc_raw_b_i,
  input  wire logic               loop_i,       // take DAC values instead
  input  wire afe_pkg::sample_t   dac_val_a_i,
  input  wire afe_pkg::sample_t   dac_val_b_i,
  output afe_pkg::sample_t        adc_a_o,
  output afe_pkg::sample_t        adc_b_o,
  output logic                    adc_valid_o   // no ready, samples not taken are lost
);

  afe_pkg::sample_t samp_a;   // converted, untrimmed
  afe_pkg::sample_t samp_b;

  // raw is inverse of two's complement
  assign samp_a = ~adc_raw_a_i;
  assign samp_b = ~adc_raw_b_i;

  //////////////////////////////
  // channel cross + trim
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (loop_i) begin
      adc_a_o <= dac_val_a_i;   // full 14 bits in loopback
      adc_b_o <= dac_val_b_i;
    end else begin
      adc_a_o <= {samp_b[`AFE_DW-1:2], 2'b00};  // adc B -> ch A, 2 LSB dropped
      adc_b_o <= {samp_a[`AFE_DW-1:2], 2'b00};  // adc A -> ch B
    end
  end

  // ADC never stalls, valid from first edge out of reset
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) adc_valid_o <= 1'b0;
    else           adc_valid_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/afe_defs.svh
`ifndef AFE_DEFS_SVH
`define AFE_DEFS_SVH

//////////////////////////////
// data path widths
//////////////////////////////

`define AFE_DW      14    // sample and pin code
`define AFE_SUM_W   15    // offset sum before saturation

//////////////////////////////
// system bus
//////////////////////////////

`define BUS_AW      23    // full address
`define BUS_DW      32
`define BUS_OFS_W   20    // offset inside one region, region no. above it
`define BUS_REGIONS 8

// identification word, returned on HK_ID
`define AFE_ID      32'h4146_4501

`define LED_W       8

// housekeeping reset values
`define LED_RST     8'h00
`define LOOP_RST    1'b0   // loopback off

`endif

//--- hw/afe_housekeeping.sv
`default_nettype none

`include "afe_defs.svh"

module afe_housekeeping (
  input  wire logic           adc_clk,
  input  wire logic           arst_n_i,
  output logic                loop_o,    // digital loopback DAC -> ADC
  output logic [`LED_W-1:0]   led_o,
  sys_bus_if.slave            bus
);

  logic [`BUS_OFS_W-1:0] reg_ofs;
  logic                  hit;        // offset is mapped

  assign reg_ofs = bus.addr[`BUS_OFS_W-1:0];
  assign hit     = reg_ofs inside {afe_pkg::HK_ID, afe_pkg::HK_LOOP, afe_pkg::HK_LED};

  //////////////////////////////
  // control registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      loop_o  <= `LOOP_RST;
      led_o   <= `LED_RST;
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= bus.wen | bus.ren;     // always one cycle later
      bus.err <= bus.ren & !hit;        // bad writes are dropped silently
      if (bus.wen) begin
        case (reg_ofs)
          afe_pkg::HK_LOOP: loop_o <= bus.wdata[0];
          afe_pkg::HK_LED:  led_o  <= bus.wdata[`LED_W-1:0];
          default: ;                    // ID is read only
        endcase
      end
    end
  end

  // read data for the ack cycle
  always_ff @(posedge adc_clk) begin
    case (reg_ofs)
      afe_pkg::HK_ID:   bus.rdata <= `AFE_ID;
      afe_pkg::HK_LOOP: bus.rdata <= {{(`BUS_DW-1){1'b0}}, loop_o};
      afe_pkg::HK_LED:  bus.rdata <= {{(`BUS_DW-`LED_W){1'b0}}, led_o};
      default:          bus.rdata <= '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/afe_pkg.sv
`default_nettype none

`include "afe_defs.svh"

package afe_pkg;

  //////////////////////////////
  // data types
  //////////////////////////////

  typedef logic signed [`AFE_DW-1:0] sample_t;    // two's complement
  typedef logic        [`AFE_DW-1:0] dac_code_t;  // neg slope, ~sample

  typedef logic [`BUS_AW-1:0] bus_addr_t;
  typedef logic [`BUS_DW-1:0] bus_data_t;

  //////////////////////////////
  // register maps
  //////////////////////////////

  // region 0
  typedef enum logic [`BUS_OFS_W-1:0] {
    HK_ID   = 'h0,
    HK_LOOP = 'h4,
    HK_LED  = 'h8
  } hk_reg_e;

  // region 1, bit 4 selects the channel
  typedef enum logic [`BUS_OFS_W-1:0] {
    GEN_A_MODE   = 'h00,
    GEN_A_STEP   = 'h04,
    GEN_A_OFFSET = 'h08,
    GEN_B_MODE   = 'h10,
    GEN_B_STEP   = 'h14,
    GEN_B_OFFSET = 'h18
  } gen_reg_e;

  typedef enum logic [1:0] {
    GEN_OFF  = 2'd0,
    GEN_DC   = 2'd1,  // offset only
    GEN_RAMP = 2'd2   // accumulator + offset
  } gen_mode_e;

endpackage

`default_nettype wire

//--- hw/afe_top.sv
`default_nettype none

`include "afe_defs.svh"

module afe_top (
  input  wire logic               adc_clk,
  input  wire logic               arst_n_i,
  // system bus
  input  wire afe_pkg::bus_addr_t sys_addr_i,
  input  wire afe_pkg::bus_data_t sys_wdata_i,
  input  wire logic               sys_wen_i,
  input  wire logic               sys_ren_i,
  output afe_pkg::bus_data_t      sys_rdata_o,
  output logic                    sys_err_o,
  output logic                    sys_ack_o,
  // ADC
  input  wire afe_pkg::dac_code_t adc_raw_a_i,
  input  wire afe_pkg::dac_code_t adc_raw_b_i,
  output afe_pkg::sample_t        adc_a_o,
  output afe_pkg::sample_t        adc_b_o,
  output logic                    adc_valid_o,
  // DAC
  input  wire logic [1:0]         temp_prot_i,
  output afe_pkg::dac_code_t      dac_dat_a_o,
  output afe_pkg::dac_code_t      dac_dat_b_o,
  output logic                    dac_reset_o,
  output logic [`LED_W-1:0]       led_o
);

  logic             digital_loop;
  afe_pkg::sample_t dac_val_a;     // generator -> ADC loopback
  afe_pkg::sample_t dac_val_b;

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if gen_bus ();  // region 1

  //////////////////////////////
  // bus decode
  //////////////////////////////

  sys_bus_decoder u_decoder (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus      (hk_bus),
    .gen_bus     (gen_bus)
  );

  afe_housekeeping u_hk (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .loop_o   (digital_loop),
    .led_o    (led_o),
    .bus      (hk_bus)
  );

  //////////////////////////////
  // analog paths
  //////////////////////////////

  dac_generator u_gen (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .temp_prot_i (temp_prot_i),
    .dac_val_a_o (dac_val_a),
    .dac_val_b_o (dac_val_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_reset_o (dac_reset_o),
    .bus         (gen_bus)
  );

  adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_raw_a_i (adc_raw_a_i),
    .adc_raw_b_i (adc_raw_b_i),
    .loop_i      (digital_loop),
    .dac_val_a_i (dac_val_a),
    .dac_val_b_i (dac_val_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o),
    .adc_valid_o (adc_valid_o)
  );

endmodule

`default_nettype wire

//--- hw/dac_generator.sv
`default_nettype none

`include "afe_defs.svh"

module dac_generator (
  input  wire logic        adc_clk,
  input  wire logic        arst_n_i,
  input  wire logic [1:0]  temp_prot_i,  // [0] ch A, [1] ch B
  output afe_pkg::sample_t  dac_val_a_o,  // current cycle, for loopback
  output afe_pkg::sample_t  dac_val_b_o,
  output afe_pkg::dac_code_t dac_dat_a_o, // pin A carries ch B
  output afe_pkg::dac_code_t dac_dat_b_o, // pin B carries ch A
  output logic             dac_reset_o,
  sys_bus_if.slave         bus
);

  afe_pkg::gen_mode_e      mode_q [2];
  afe_pkg::sample_t        step_q [2];
  afe_pkg::sample_t        ofs_q  [2];
  afe_pkg::sample_t        acc_q  [2];   // ramp, wraps at 14 bits
  afe_pkg::sample_t        base   [2];
  afe_pkg::sample_t        val    [2];
  logic signed [`AFE_SUM_W-1:0] sum [2];
  afe_pkg::dac_code_t      code_q [2];
  logic [`BUS_OFS_W-1:0]   reg_ofs;
  logic                    ch;           // channel of the bus access
  logic                    hit;
  logic                    mode_wr;
  logic                    rst_q;

  assign reg_ofs = bus.addr[`BUS_OFS_W-1:0];
  assign ch      = reg_ofs[4];
  assign hit     = reg_ofs inside {afe_pkg::GEN_A_MODE, afe_pkg::GEN_A_STEP,
                                   afe_pkg::GEN_A_OFFSET, afe_pkg::GEN_B_MODE,
                                   afe_pkg::GEN_B_STEP, afe_pkg::GEN_B_OFFSET};
  assign mode_wr = bus.wen & (reg_ofs == afe_pkg::GEN_A_MODE |
                              reg_ofs == afe_pkg::GEN_B_MODE);

  //////////////////////////////
  // config and accumulators
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int c = 0; c < 2; c++) begin
        mode_q[c] <= afe_pkg::GEN_OFF;
        step_q[c] <= '0;
        ofs_q[c]  <= '0;
        acc_q[c]  <= '0;
      end
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= bus.ren & !hit;
      if (bus.wen) begin
        case (reg_ofs)
          afe_pkg::GEN_A_MODE, afe_pkg::GEN_B_MODE:
            mode_q[ch] <= afe_pkg::gen_mode_e'(bus.wdata[1:0]);
          afe_pkg::GEN_A_STEP, afe_pkg::GEN_B_STEP:
            step_q[ch] <= bus.wdata[`AFE_DW-1:0];
          afe_pkg::GEN_A_OFFSET, afe_pkg::GEN_B_OFFSET:
            ofs_q[ch]  <= bus.wdata[`AFE_DW-1:0];
          default: ;
        endcase
      end
      for (int c = 0; c < 2; c++) begin
        if (mode_wr && ch == 1'(c)) acc_q[c] <= '0;        // restart on mode write
        else if (mode_q[c] == afe_pkg::GEN_RAMP) acc_q[c] <= acc_q[c] + step_q[c];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    case (reg_ofs)
      afe_pkg::GEN_A_MODE, afe_pkg::GEN_B_MODE:
        bus.rdata <= {{(`BUS_DW-2){1'b0}}, mode_q[ch]};
      afe_pkg::GEN_A_STEP, afe_pkg::GEN_B_STEP:
        bus.rdata <= {{(`BUS_DW-`AFE_DW){1'b0}}, step_q[ch]};
      afe_pkg::GEN_A_OFFSET, afe_pkg::GEN_B_OFFSET:
        bus.rdata <= {{(`BUS_DW-`AFE_DW){1'b0}}, ofs_q[ch]};
      default:
        bus.rdata <= '0;
    endcase
  end

  //////////////////////////////
  // value, saturation
  //////////////////////////////

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      base[c] = (mode_q[c] == afe_pkg::GEN_RAMP) ? acc_q[c] : '0;  // DC has no ramp
      sum[c]  = `AFE_SUM_W'(base[c]) + `AFE_SUM_W'(ofs_q[c]);       // sign extended
      // top two bits differ -> clip to full scale
      if (sum[c][`AFE_SUM_W-1] != sum[c][`AFE_SUM_W-2])
        val[c] = {sum[c][`AFE_SUM_W-1], {(`AFE_DW-1){~sum[c][`AFE_SUM_W-1]}}};
      else
        val[c] = sum[c][`AFE_DW-1:0];
      // off, unknown mode or overheated
      if (!(mode_q[c] inside {afe_pkg::GEN_DC, afe_pkg::GEN_RAMP}) || temp_prot_i[c])
        val[c] = '0;
    end
  end

  assign dac_val_a_o = val[0];
  assign dac_val_b_o = val[1];

  //////////////////////////////
  // DAC pins
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      code_q[0]   <= '1;   // code of 0
      code_q[1]   <= '1;
      dac_dat_a_o <= '1;
      dac_dat_b_o <= '1;
      rst_q       <= 1'b1;
      dac_reset_o <= 1'b1;
    end else begin
      code_q[0]   <= ~val[0];   // neg slope code
      code_q[1]   <= ~val[1];
      dac_dat_a_o <= code_q[1]; // cross ch B -> pin A
      dac_dat_b_o <= code_q[0]; // cross ch A -> pin B
      rst_q       <= 1'b0;
      dac_reset_o <= rst_q;     // stretched by one edge
    end
  end

endmodule

`default_nettype wire

//--- hw/sys_bus_decoder.sv
`default_nettype none

`include "afe_defs.svh"

module sys_bus_decoder (
  input  wire logic              adc_clk,
  input  wire logic              arst_n_i,
  input  wire afe_pkg::bus_addr_t sys_addr_i,
  input  wire afe_pkg::bus_data_t sys_wdata_i,
  input  wire logic              sys_wen_i,
  input  wire logic              sys_ren_i,
  output afe_pkg::bus_data_t     sys_rdata_o,
  output logic                   sys_err_o,
  output logic                   sys_ack_o,
  sys_bus_if.master              hk_bus,
  sys_bus_if.master              gen_bus
);

  logic [$clog2(`BUS_REGIONS)-1:0] region;    // region of current request
  logic [$clog2(`BUS_REGIONS)-1:0] region_q;  // region of last request
  logic                            req;
  logic                            stub_ack_q;

  assign region = sys_addr_i[`BUS_AW-1:`BUS_OFS_W];
  assign req    = sys_wen_i | sys_ren_i;

  //////////////////////////////
  // request routing
  //////////////////////////////

  // addr and data fan out, only strobes are steered
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.wen    = sys_wen_i & (region == 'd0);
  assign hk_bus.ren    = sys_ren_i & (region == 'd0);

  assign gen_bus.addr  = sys_addr_i;
  assign gen_bus.wdata = sys_wdata_i;
  assign gen_bus.wen   = sys_wen_i & (region == 'd1);
  assign gen_bus.ren   = sys_ren_i & (region == 'd1);

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      region_q   <= '0;
      stub_ack_q <= 1'b0;
    end else begin
      if (req) region_q <= region;             // held until next request
      stub_ack_q <= req & (region > 'd1);     // regions 2..7, no slave
    end
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb begin
    case (region_q)
      'd0: begin
        sys_rdata_o = hk_bus.rdata;
        sys_err_o   = hk_bus.err;
        sys_ack_o   = hk_bus.ack;
      end
      'd1: begin
        sys_rdata_o = gen_bus.rdata;
        sys_err_o   = gen_bus.err;
        sys_ack_o   = gen_bus.ack;
      end
      default: begin  // stub answers empty
        sys_rdata_o = '0;
        sys_err_o   = 1'b0;
        sys_ack_o   = stub_ack_q;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/sys_bus_if.sv
`default_nettype none

`include "afe_defs.svh"

// request/ack register bus
// a request is a single cycle wen or ren pulse,
// the slave answers with ack in the very next cycle
interface sys_bus_if;

  logic [`BUS_AW-1:0] addr;
  logic [`BUS_DW-1:0] wdata;
  logic               wen;
  logic               ren;
  logic [`BUS_DW-1:0] rdata;  // valid with ack
  logic               err;    // valid with ack
  logic               ack;

  modport master (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  err,
    input  ack
  );

  modport slave (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output err,
    output ack
  );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the afe testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing -f sim.f --top-module afe_tb -o afe_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/afe_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0

//--- sim.f
+incdir+hw
hw/afe_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/afe_housekeeping.sv
hw/dac_generator.sv
hw/adc_frontend.sv
hw/afe_top.sv
tb/afe_tb.sv

//--- tb/afe_tb.sv
`default_nettype none

`include "afe_defs.svh"

module afe_tb;

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // run length
  //////////////////////////////

  localparam int RST_CYC      = 10;
  localparam int ADC_SAMPLES  = 32;
  localparam int RAMP_STEPS   = 40;   // past full scale and the 14 bit wrap
  localparam int T_ID_CYC     = 20;
  localparam int T_ERR_CYC    = 30;
  localparam int T_ADC_CYC    = ADC_SAMPLES + 5;
  localparam int T_DC_CYC     = 30;
  localparam int T_RAMP_CYC   = RAMP_STEPS + 15;
  localparam int T_OFF_CYC    = 25;
  localparam int TIMEOUT_CYC  = 2 * (RST_CYC + T_ID_CYC + T_ERR_CYC + T_ADC_CYC +
                                     T_DC_CYC + T_RAMP_CYC + T_OFF_CYC);

  logic                 adc_clk;
  logic                 arst_n;
  afe_pkg::bus_addr_t   sys_addr;
  afe_pkg::bus_data_t   sys_wdata;
  logic                 sys_wen;
  logic                 sys_ren;
  afe_pkg::bus_data_t   sys_rdata;
  logic                 sys_err;
  logic                 sys_ack;
  afe_pkg::dac_code_t   adc_raw_a;
  afe_pkg::dac_code_t   adc_raw_b;
  afe_pkg::sample_t     adc_a;
  afe_pkg::sample_t     adc_b;
  logic                 adc_valid;
  logic [1:0]           temp_prot;
  afe_pkg::dac_code_t   dac_dat_a;
  afe_pkg::dac_code_t   dac_dat_b;
  logic                 dac_reset;
  logic [`LED_W-1:0]    led;

  integer               seed = 32'hef3a_1e0c;
  int                   ack_cycles;       // latency of the last bus access
  int unsigned          cycle_cnt = 0;
  afe_pkg::sample_t     off_a;            // DC offsets of channels A and B
  afe_pkg::sample_t     off_b;

  afe_top dut0 (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_err_o   (sys_err),
    .sys_ack_o   (sys_ack),
    .adc_raw_a_i (adc_raw_a),
    .adc_raw_b_i (adc_raw_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .adc_valid_o (adc_valid),
    .temp_prot_i (temp_prot),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .dac_reset_o (dac_reset),
    .led_o       (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;   // 100 MHz
  end

  // watchdog
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Done: errors found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  //////////////////////////////
  // failure and compare tasks
  //////////////////////////////

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic cmp_data(input string name, input afe_pkg::bus_data_t got,
                          input afe_pkg::bus_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic cmp_code(input string name, input afe_pkg::dac_code_t got,
                          input afe_pkg::dac_code_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic cmp_sample(input string name, input afe_pkg::sample_t got,
                            input afe_pkg::sample_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////
  // bus access
  //////////////////////////////

  function automatic afe_pkg::bus_addr_t reg_addr(input logic [2:0] region,
                                                  input logic [`BUS_OFS_W-1:0] ofs);
    return {region, ofs};   // region no. on top
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  // called at the negedge after the request edge
  task automatic wait_ack();
    ack_cycles = 1;
    while (!sys_ack) begin
      @(negedge adc_clk);
      ack_cycles++;
      if (ack_cycles > 4)
        report_failure("bus request got no ack within 4 cycles");
    end
  endtask

  task automatic check_latency();
    if (ack_cycles != 1)
      report_failure("bus ack did not come one cycle after the request");
  endtask

  task automatic bus_write(input afe_pkg::bus_addr_t addr, input afe_pkg::bus_data_t data);
    @(negedge adc_clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;      // one cycle pulse
    @(negedge adc_clk);
    sys_wen   = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input afe_pkg::bus_addr_t addr, output afe_pkg::bus_data_t data,
                          output logic err);
    @(negedge adc_clk);
    sys_addr = addr;
    sys_ren  = 1'b1;
    @(negedge adc_clk);
    sys_ren  = 1'b0;
    wait_ack();
    data = sys_rdata;      // valid with ack only
    err  = sys_err;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_id();
    afe_pkg::bus_data_t rdata;
    logic               err;
    logic [31:0]        rnd;
    logic [`LED_W-1:0]  led_val;
    wait_cycles(2);                        // dac reset stretch over
    cmp_code("dac_dat_a_o", dac_dat_a, 14'h3FFF);
    cmp_code("dac_dat_b_o", dac_dat_b, 14'h3FFF);
    cmp_bit("dac_reset_o", dac_reset, 1'b0);
    cmp_bit("adc_valid_o", adc_valid, 1'b1);
    bus_read(reg_addr(3'd0, afe_pkg::HK_ID), rdata, err);
    check_latency();
    cmp_data("sys_rdata_o", rdata, `AFE_ID);
    cmp_bit("sys_err_o", err, 1'b0);
    rnd     = $random(seed);
    led_val = rnd[`LED_W-1:0];
    bus_write(reg_addr(3'd0, afe_pkg::HK_LED), {{(`BUS_DW-`LED_W){1'b0}}, led_val});
    check_latency();
    cmp_data("led_o", {{(`BUS_DW-`LED_W){1'b0}}, led}, {{(`BUS_DW-`LED_W){1'b0}}, led_val});
    bus_read(reg_addr(3'd0, afe_pkg::HK_LED), rdata, err);
    check_latency();
    cmp_data("sys_rdata_o", rdata, {{(`BUS_DW-`LED_W){1'b0}}, led_val});
  endtask

  task automatic test_bus_errors();
    afe_pkg::bus_data_t rdata;
    logic               err;
    logic [31:0]        rnd;
    bus_read(reg_addr(3'd0, 20'h0000C), rdata, err);   // hole in region 0
    cmp_data("sys_rdata_o", rdata, '0);
    cmp_bit("sys_err_o", err, 1'b1);
    for (int r = 2; r < `BUS_REGIONS; r++) begin
      rnd = $random(seed);
      bus_read(reg_addr(3'(r), rnd[`BUS_OFS_W-1:0]), rdata, err);
      cmp_data("sys_rdata_o", rdata, '0);
      cmp_bit("sys_err_o", err, 1'b0);
    end
  endtask

  task automatic test_adc_path();
    logic [31:0]        rnd;
    afe_pkg::dac_code_t raw_a_prev;
    afe_pkg::dac_code_t raw_b_prev;
    afe_pkg::sample_t   exp_a;
    afe_pkg::sample_t   exp_b;
    raw_a_prev = '0;
    raw_b_prev = '0;
    @(negedge adc_clk);
    for (int i = 0; i <= ADC_SAMPLES; i++) begin
      if (i > 0) begin
        exp_a      = ~raw_b_prev;   // cross B -> A
        exp_a[1:0] = 2'b00;
        exp_b      = ~raw_a_prev;
        exp_b[1:0] = 2'b00;
        cmp_sample("adc_a_o", adc_a, exp_a);
        cmp_sample("adc_b_o", adc_b, exp_b);
        cmp_bit("adc_valid_o", adc_valid, 1'b1);
      end
      rnd        = $random(seed);
      adc_raw_a  = rnd[`AFE_DW-1:0];
      adc_raw_b  = rnd[`AFE_DW+15:16];
      raw_a_prev = adc_raw_a;
      raw_b_prev = adc_raw_b;
      @(negedge adc_clk);
    end
  endtask

  task automatic test_dc_loop();
    logic [31:0] rnd;
    rnd   = $random(seed);
    off_a = rnd[`AFE_DW-1:0];
    off_b = rnd[`AFE_DW+15:16];
    if (off_b == off_a) off_b = ~off_a;    // crossing must be visible
    bus_write(reg_addr(3'd1, afe_pkg::GEN_A_OFFSET), {{(`BUS_DW-`AFE_DW){1'b0}}, off_a});
    bus_write(reg_addr(3'd1, afe_pkg::GEN_B_OFFSET), {{(`BUS_DW-`AFE_DW){1'b0}}, off_b});
    bus_write(reg_addr(3'd1, afe_pkg::GEN_A_MODE), {30'b0, afe_pkg::GEN_DC});
    bus_write(reg_addr(3'd1, afe_pkg::GEN_B_MODE), {30'b0, afe_pkg::GEN_DC});
    wait_cycles(3);                        // code reg + pin reg
    cmp_code("dac_dat_b_o", dac_dat_b, ~off_a);
    cmp_code("dac_dat_a_o", dac_dat_a, ~off_b);
    bus_write(reg_addr(3'd0, afe_pkg::HK_LOOP), 32'h1);
    wait_cycles(2);
    cmp_sample("adc_a_o", adc_a, off_a);   // untrimmed in loopback
    cmp_sample("adc_b_o", adc_b, off_b);
    bus_write(reg_addr(3'd0, afe_pkg::HK_LOOP), 32'h0);
  endtask

  task automatic test_ramp();
    logic [`AFE_DW-1:0] acc_m;            // model of the accumulator
    afe_pkg::sample_t   acc_s;
    afe_pkg::sample_t   exp_val;
    int                 sum_m;
    bus_write(reg_addr(3'd1, afe_pkg::GEN_A_OFFSET), 32'h0000_1000);
    bus_write(reg_addr(3'd1, afe_pkg::GEN_A_STEP), 32'h0000_0100);
    bus_write(reg_addr(3'd1, afe_pkg::GEN_A_MODE), {30'b0, afe_pkg::GEN_RAMP});
    check_latency();                       // k counts from the mode write edge
    wait_cycles(2);
    for (int k = 0; k < RAMP_STEPS; k++) begin
      acc_m = `AFE_DW'(k * 'h100);         // wraps at 14 bits
      acc_s = acc_m;
      sum_m = int'(acc_s) + 'h1000;
      if (sum_m > 8191) sum_m = 8191;      // clip to 14 bit signed
      else if (sum_m < -8192) sum_m = -8192;
      exp_val = `AFE_DW'(sum_m);
      cmp_code("dac_dat_b_o", dac_dat_b, ~exp_val);
      wait_cycles(1);
    end
  endtask

  task automatic test_temp_off();
    afe_pkg::bus_data_t rdata;
    logic               err;
    temp_prot = 2'b01;                     // ch A overheated
    wait_cycles(3);
    cmp_code("dac_dat_b_o", dac_dat_b, 14'h3FFF);
    cmp_code("dac_dat_a_o", dac_dat_a, ~off_b);   // ch B still on its DC offset
    bus_write(reg_addr(3'd1, afe_pkg::GEN_B_MODE), {30'b0, afe_pkg::GEN_OFF});
    wait_cycles(3);
    cmp_code("dac_dat_a_o", dac_dat_a, 14'h3FFF);
    bus_read(reg_addr(3'd1, afe_pkg::GEN_B_MODE), rdata, err);
    cmp_data("sys_rdata_o", rdata, {30'b0, afe_pkg::GEN_OFF});
    cmp_bit("sys_err_o", err, 1'b0);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    arst_n    = 1'b0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    adc_raw_a = '1;            // raw code of 0
    adc_raw_b = '1;
    temp_prot = 2'b00;
    repeat (RST_CYC) @(negedge adc_clk);
    arst_n = 1'b1;
    test_reset_id();
    test_bus_errors();
    test_adc_path();
    test_dc_loop();
    test_ramp();
    test_temp_off();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
